// File: dii_pkg.sv
`default_nettype none

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for the debug interconnect ring
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package dii_pkg;

  localparam int dii_data_bits   = 16; // flit payload width.
  localparam int dii_id_bits     = 16; // endpoint id width.
  localparam int dii_subnet_bits = 6;  // subnet field, fixed by the id format.

  // endpoint number below the subnet field.
  localparam int dii_endpoint_bits = dii_id_bits - dii_subnet_bits;

  typedef logic [dii_data_bits-1:0]   dii_data_t;   // payload or destination id.
  typedef logic [dii_id_bits-1:0]     dii_id_t;     // full endpoint id.
  typedef logic [dii_subnet_bits-1:0] dii_subnet_t; // top bits of an id.

  // one flit of a worm, first flit holds the destination id.
  typedef struct packed {
    dii_data_t data;  // payload.
    logic      last;  // final flit of the worm.
    logic      valid; // sender has a flit.
  } dii_flit;

endpackage

`default_nettype wire

// File: dii_flit_reg.sv
`timescale 1ns/100ps
`default_nettype none

// two-entry skid slice, ready and valid both come from flops.
module dii_flit_reg (
  input  logic             clk,
  input  logic             rst,
  input  dii_pkg::dii_flit in_flit,
  output logic             in_ready,
  output dii_pkg::dii_flit out_flit,
  input  logic             out_ready
);

  logic               out_valid;  // main entry holds a flit.
  logic               skid_valid; // overflow entry holds a flit.
  dii_pkg::dii_data_t out_data;
  logic               out_last;
  dii_pkg::dii_data_t skid_data;
  logic               skid_last;
  logic               out_free;   // main entry may load this cycle.
  logic               in_xfer;    // input flit taken this cycle.

  assign in_ready = ~skid_valid;             // space left while skid is empty.
  assign out_free = out_ready | ~out_valid;  // consumer takes or entry is empty.
  assign in_xfer  = in_flit.valid & ~skid_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_free) begin
      out_valid  <= skid_valid | in_xfer; // skid drains first.
      skid_valid <= 1'b0;
    end else if (in_xfer) begin
      skid_valid <= 1'b1;                 // output stalled, park the flit.
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) begin
      out_data <= skid_valid ? skid_data : in_flit.data;
      out_last <= skid_valid ? skid_last : in_flit.last;
    end
    if (!out_free && in_xfer) begin
      skid_data <= in_flit.data;
      skid_last <= in_flit.last;
    end
  end

  always_comb begin
    out_flit.data  = out_data;
    out_flit.last  = out_last;
    out_flit.valid = out_valid;
  end

endmodule

`default_nettype wire

// File: dii_worm_mux.sv
`timescale 1ns/100ps
`default_nettype none

// two-to-one worm arbiter, input 0 wins, a grant covers a whole worm.
module dii_worm_mux (
  input  logic             clk,
  input  logic             rst,
  input  dii_pkg::dii_flit in0,
  output logic             in0_ready,
  input  dii_pkg::dii_flit in1,
  output logic             in1_ready,
  output dii_pkg::dii_flit out_flit,
  input  logic             out_ready
);

  logic busy;  // a worm is in flight.
  logic grant; // input owning the current worm.
  logic sel;   // input routed this cycle.
  logic xfer;  // flit leaves the mux.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // selection, only looked at while idle
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign sel = busy ? grant : ~in0.valid; // in0 first when idle.

  assign out_flit  = sel ? in1 : in0;
  assign in0_ready = out_ready & ~sel;    // loser sees no ready.
  assign in1_ready = out_ready & sel;
  assign xfer      = out_flit.valid & out_ready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // worm tracking
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      busy  <= 1'b0;
      grant <= 1'b0;
    end else if (!busy) begin
      if (xfer && !out_flit.last) begin
        busy  <= 1'b1; // single-flit worms never lock.
        grant <= sel;
      end
    end else if (xfer && out_flit.last) begin
      busy <= 1'b0;    // tail gone, arbitrate again.
    end
  end

endmodule

`default_nettype wire

// File: dii_ring_node.sv
`timescale 1ns/100ps
`default_nettype none

// ring endpoint: eject own worms, inject local worms, register the ring side.
module dii_ring_node #(
  parameter dii_pkg::dii_id_t NODE_ID = '0
) (
  input  logic             clk,
  input  logic             rst,
  input  dii_pkg::dii_flit ring_in,
  output logic             ring_in_ready,
  output dii_pkg::dii_flit ring_out,
  input  logic             ring_out_ready,
  input  dii_pkg::dii_flit local_in,
  output logic             local_in_ready,
  output dii_pkg::dii_flit local_out,
  input  logic             local_out_ready
);

  logic             worm;       // ring worm past its first flit.
  logic             worm_eject; // latched decision for that worm.
  logic             is_match;   // head flit addresses this node.
  logic             eject;      // decision in force this cycle.
  logic             ring_xfer;  // ring flit accepted.
  dii_pkg::dii_flit pass_flit;  // traffic staying on the ring.
  logic             pass_ready;
  dii_pkg::dii_flit mux_flit;   // arbiter output into the slice.
  logic             mux_ready;

  assign is_match  = (ring_in.data == NODE_ID);
  assign eject     = worm ? worm_eject : is_match;
  assign ring_xfer = ring_in.valid & ring_in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      worm       <= 1'b0;
      worm_eject <= 1'b0;
    end else if (!worm) begin
      if (ring_xfer && !ring_in.last) begin
        worm       <= 1'b1;
        worm_eject <= is_match; // hold for the body flits.
      end
    end else if (ring_xfer && ring_in.last) begin
      worm <= 1'b0;
    end
  end

  always_comb begin
    local_out.data  = ring_in.data;
    local_out.last  = ring_in.last;
    local_out.valid = ring_in.valid & eject;
    pass_flit.data  = ring_in.data;
    pass_flit.last  = ring_in.last;
    pass_flit.valid = ring_in.valid & ~eject;
    ring_in_ready   = eject ? local_out_ready : pass_ready;
  end

  // ring traffic on input 0 so it never waits behind injection.
  dii_worm_mux u_mux (
    .clk       (clk),
    .rst       (rst),
    .in0       (pass_flit),
    .in0_ready (pass_ready),
    .in1       (local_in),
    .in1_ready (local_in_ready),
    .out_flit  (mux_flit),
    .out_ready (mux_ready)
  );

  dii_flit_reg u_reg (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (mux_flit),
    .in_ready  (mux_ready),
    .out_flit  (ring_out),
    .out_ready (ring_out_ready)
  );

endmodule

`default_nettype wire

// File: dii_ring_ingress.sv
`timescale 1ns/100ps
`default_nettype none

// ring entry point, returning traffic merged ahead of external worms.
module dii_ring_ingress (
  input  logic             clk,
  input  logic             rst,
  input  dii_pkg::dii_flit ring_in,
  output logic             ring_in_ready,
  input  dii_pkg::dii_flit ext_in,
  output logic             ext_in_ready,
  output dii_pkg::dii_flit ring_out,
  input  logic             ring_out_ready
);

  dii_pkg::dii_flit mux_flit; // merged stream.
  logic             mux_ready;

  dii_worm_mux u_mux (
    .clk       (clk),
    .rst       (rst),
    .in0       (ring_in),      // ring return first, else the ring jams.
    .in0_ready (ring_in_ready),
    .in1       (ext_in),
    .in1_ready (ext_in_ready),
    .out_flit  (mux_flit),
    .out_ready (mux_ready)
  );

  // cuts the valid/ready loop around the ring.
  dii_flit_reg u_reg (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (mux_flit),
    .in_ready  (mux_ready),
    .out_flit  (ring_out),
    .out_ready (ring_out_ready)
  );

endmodule

`default_nettype wire

// File: dii_gateway_demux.sv
`timescale 1ns/100ps
`default_nettype none

// end of the ring: gateway-local, off-subnet, or back around.
module dii_gateway_demux #(
  parameter dii_pkg::dii_subnet_t LOCAL_SUBNET = '0
) (
  input  logic             clk,
  input  logic             rst,
  input  dii_pkg::dii_flit in_ring,
  output logic             in_ring_ready,
  output dii_pkg::dii_flit out_local,
  input  logic             out_local_ready,
  output dii_pkg::dii_flit out_ext,
  input  logic             out_ext_ready,
  output dii_pkg::dii_flit out_ring,
  input  logic             out_ring_ready
);

  // gateway owns endpoint zero of its subnet.
  localparam dii_pkg::dii_id_t gw_id =
    dii_pkg::dii_id_t'(dii_pkg::dii_id_t'(LOCAL_SUBNET) << dii_pkg::dii_endpoint_bits);

  dii_pkg::dii_subnet_t head_subnet; // subnet field of the current flit.
  logic                 is_local;
  logic                 is_ext;
  logic                 worm;        // worm past its first flit.
  logic                 worm_local;
  logic                 worm_ext;
  logic                 sw_local;    // choice in force this cycle.
  logic                 sw_ext;
  logic                 xfer;

  assign head_subnet = in_ring.data[dii_pkg::dii_id_bits-1 -: dii_pkg::dii_subnet_bits];
  assign is_local    = (in_ring.data == gw_id);
  assign is_ext      = (head_subnet != LOCAL_SUBNET);
  assign sw_local    = worm ? worm_local : is_local;
  assign sw_ext      = worm ? worm_ext : is_ext;
  assign xfer        = in_ring.valid & in_ring_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      worm       <= 1'b0;
      worm_local <= 1'b0;
      worm_ext   <= 1'b0;
    end else if (!worm) begin
      if (xfer && !in_ring.last) begin
        worm       <= 1'b1;
        worm_local <= is_local; // classified on the head only.
        worm_ext   <= is_ext;
      end
    end else if (xfer && in_ring.last) begin
      worm <= 1'b0;
    end
  end

  always_comb begin
    out_local       = in_ring;
    out_ext         = in_ring;
    out_ring        = in_ring;
    out_local.valid = 1'b0;
    out_ext.valid   = 1'b0;
    out_ring.valid  = 1'b0;
    if (sw_local) begin
      out_local.valid = in_ring.valid; // own id wins over the subnet test.
      in_ring_ready   = out_local_ready;
    end else if (sw_ext) begin
      out_ext.valid = in_ring.valid;
      in_ring_ready = out_ext_ready;
    end else begin
      out_ring.valid = in_ring.valid;  // local subnet, goes around again.
      in_ring_ready  = out_ring_ready;
    end
  end

endmodule

`default_nettype wire

// File: dii_ring_top.sv
`timescale 1ns/100ps
`default_nettype none

// debug ring: ingress, NODES endpoints, gateway back to the ingress.
module dii_ring_top #(
  parameter int                   NODES        = 3,
  parameter dii_pkg::dii_subnet_t LOCAL_SUBNET = '0
) (
  input  logic             clk,
  input  logic             rst,
  input  dii_pkg::dii_flit ext_in,
  output logic             ext_in_ready,
  output dii_pkg::dii_flit ext_out,
  input  logic             ext_out_ready,
  output dii_pkg::dii_flit gw_local,
  input  logic             gw_local_ready,
  input  dii_pkg::dii_flit node_in [NODES],
  output logic [NODES-1:0] node_in_ready,
  output dii_pkg::dii_flit node_out [NODES],
  input  logic [NODES-1:0] node_out_ready
);

  dii_pkg::dii_flit ring_link [NODES+1]; // link i feeds node i, last feeds gateway.
  logic [NODES:0]   ring_ready;
  dii_pkg::dii_flit ring_ret;            // gateway back to ingress.
  logic             ring_ret_ready;

  dii_ring_ingress u_ingress (
    .clk            (clk),
    .rst            (rst),
    .ring_in        (ring_ret),
    .ring_in_ready  (ring_ret_ready),
    .ext_in         (ext_in),
    .ext_in_ready   (ext_in_ready),
    .ring_out       (ring_link[0]),
    .ring_out_ready (ring_ready[0])
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // endpoints, node i answers to endpoint i+1
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar i = 0; i < NODES; i++) begin : g_node
    localparam dii_pkg::dii_id_t node_id = dii_pkg::dii_id_t'(
      (dii_pkg::dii_id_t'(LOCAL_SUBNET) << dii_pkg::dii_endpoint_bits) |
      dii_pkg::dii_id_t'(i + 1));

    dii_ring_node #(
      .NODE_ID (node_id)
    ) u_node (
      .clk             (clk),
      .rst             (rst),
      .ring_in         (ring_link[i]),
      .ring_in_ready   (ring_ready[i]),
      .ring_out        (ring_link[i+1]),
      .ring_out_ready  (ring_ready[i+1]),
      .local_in        (node_in[i]),
      .local_in_ready  (node_in_ready[i]),
      .local_out       (node_out[i]),
      .local_out_ready (node_out_ready[i])
    );
  end

  dii_gateway_demux #(
    .LOCAL_SUBNET (LOCAL_SUBNET)
  ) u_gateway (
    .clk             (clk),
    .rst             (rst),
    .in_ring         (ring_link[NODES]),
    .in_ring_ready   (ring_ready[NODES]),
    .out_local       (gw_local),
    .out_local_ready (gw_local_ready),
    .out_ext         (ext_out),
    .out_ext_ready   (ext_out_ready),
    .out_ring        (ring_ret),       // closes the loop.
    .out_ring_ready  (ring_ret_ready)
  );

endmodule

`default_nettype wire

// File: tb_dii_ring_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dii_ring_top;

  localparam int                   nodes        = 3;
  localparam dii_pkg::dii_subnet_t local_subnet = 6'd5;
  localparam dii_pkg::dii_id_t     gw_id        = {local_subnet, 10'd0}; // endpoint zero.
  localparam int                   outs         = nodes + 2; // node_out, ext_out, gw_local.
  localparam int                   rows         = 15;
  localparam int                   groups       = 5;
  localparam int                   max_cycles   = 2000;

  typedef struct packed {
    logic [2:0]         grp;   // rows of one group start together.
    logic [2:0]         src;   // node index or nodes for ext_in.
    dii_pkg::dii_id_t   dest;
    logic [3:0]         len;   // flits including the head.
    dii_pkg::dii_data_t start; // first payload word.
  } worm_row;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // worm table with one source per output inside a group
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  worm_row worm_table [rows] = '{
    '{3'd0, 3'd3, 16'h1401, 4'd4, 16'h1000}, // ext_in to every node.
    '{3'd0, 3'd3, 16'h1402, 4'd3, 16'h1100},
    '{3'd0, 3'd3, 16'h1403, 4'd5, 16'h1200},
    '{3'd1, 3'd0, 16'h0801, 4'd3, 16'h2000}, // off subnet.
    '{3'd1, 3'd1, 16'h1400, 4'd4, 16'h2100}, // gateway id.
    '{3'd2, 3'd2, 16'h1401, 4'd4, 16'h3000}, // wraps through the ingress.
    '{3'd3, 3'd3, 16'h1402, 4'd3, 16'h4000}, // all ports at once.
    '{3'd3, 3'd0, 16'h1403, 4'd4, 16'h4100},
    '{3'd3, 3'd1, 16'h0801, 4'd5, 16'h4200},
    '{3'd3, 3'd2, 16'h1400, 4'd3, 16'h4300},
    '{3'd4, 3'd3, 16'h1403, 4'd6, 16'h5000},
    '{3'd4, 3'd3, 16'h1401, 4'd2, 16'h5100},
    '{3'd4, 3'd0, 16'h1402, 4'd3, 16'h5200},
    '{3'd4, 3'd1, 16'h1400, 4'd4, 16'h5300},
    '{3'd4, 3'd2, 16'h2C07, 4'd5, 16'h5400}
  };

  logic             clk = 1'b0;
  logic             rst;
  dii_pkg::dii_flit ext_in;
  logic             ext_in_ready;
  dii_pkg::dii_flit ext_out;
  logic             ext_out_ready;
  dii_pkg::dii_flit gw_local;
  logic             gw_local_ready;
  dii_pkg::dii_flit node_in [nodes];
  logic [nodes-1:0] node_in_ready;
  dii_pkg::dii_flit node_out [nodes];
  logic [nodes-1:0] node_out_ready;

  dii_pkg::dii_flit src_q [nodes+1][$]; // flits still to send on each input.
  dii_pkg::dii_flit exp_q [outs][$];    // flits still expected on each output.
  logic [outs-1:0]  at_head = '1;       // next flit on that output is a head.
  int               seed    = 56543;

  always #50 clk = ~clk;

  dii_ring_top #(
    .NODES        (nodes),
    .LOCAL_SUBNET (local_subnet)
  ) u_dii_ring_top (
    .clk            (clk),
    .rst            (rst),
    .ext_in         (ext_in),
    .ext_in_ready   (ext_in_ready),
    .ext_out        (ext_out),
    .ext_out_ready  (ext_out_ready),
    .gw_local       (gw_local),
    .gw_local_ready (gw_local_ready),
    .node_in        (node_in),
    .node_in_ready  (node_in_ready),
    .node_out       (node_out),
    .node_out_ready (node_out_ready)
  );

  function automatic string out_name(input int o);
    if (o < nodes) return $sformatf("node_out[%0d]", o);
    else if (o == nodes) return "ext_out";
    else return "gw_local";
  endfunction

  function automatic dii_pkg::dii_flit out_at(input int o);
    if (o < nodes) return node_out[o];
    else if (o == nodes) return ext_out;
    else return gw_local;
  endfunction

  function automatic logic out_ready_at(input int o);
    if (o < nodes) return node_out_ready[o];
    else if (o == nodes) return ext_out_ready;
    else return gw_local_ready;
  endfunction

  // gateway id first, then foreign subnet, else an endpoint.
  function automatic int route(input dii_pkg::dii_id_t dest);
    dii_pkg::dii_subnet_t sub;
    sub = dest[15 -: dii_pkg::dii_subnet_bits];
    if (dest == gw_id) return nodes + 1;
    else if (sub != local_subnet) return nodes;
    else return int'(dest[15-dii_pkg::dii_subnet_bits:0]) - 1; // node i is endpoint i+1.
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int p = 0; p <= nodes; p++)
      n += src_q[p].size();
    for (int o = 0; o < outs; o++)
      n += exp_q[o].size();
    return n;
  endfunction

  // no output presents a flit and every input port takes a new worm.
  function automatic logic ring_idle();
    logic idle;
    idle = ext_in_ready && !ext_out.valid && !gw_local.valid;
    for (int o = 0; o < nodes; o++)
      idle &= node_in_ready[o] && !node_out[o].valid;
    return idle;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_flit(input string name, input dii_pkg::dii_flit exp,
                            input dii_pkg::dii_flit act);
    if (act.data !== exp.data || act.last !== exp.last)
      abort_run($sformatf("FAILED %s: expected data %h last %b, actual data %h last %b",
                          name, exp.data, exp.last, act.data, act.last));
  endtask

  task automatic check_id(input string name, input dii_pkg::dii_id_t exp,
                          input dii_pkg::dii_id_t act);
    if (act !== exp)
      abort_run($sformatf("FAILED %s: expected id %h, actual id %h", name, exp, act));
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model, drivers and monitor
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic load_group(input int g);
    dii_pkg::dii_flit f;
    int               o;
    for (int r = 0; r < rows; r++) begin
      if (int'(worm_table[r].grp) == g) begin
        o = route(worm_table[r].dest);
        f = '{data: worm_table[r].dest, last: 1'b0, valid: 1'b1}; // head carries the id.
        src_q[worm_table[r].src].push_back(f);
        exp_q[o].push_back(f);
        for (int k = 1; k < int'(worm_table[r].len); k++) begin
          f.data = dii_pkg::dii_data_t'(int'(worm_table[r].start) + k - 1);
          f.last = (k == int'(worm_table[r].len) - 1);
          src_q[worm_table[r].src].push_back(f);
          exp_q[o].push_back(f);
        end
      end
    end
  endtask

  task automatic watch_outputs(input string name);
    dii_pkg::dii_flit act;
    dii_pkg::dii_flit exp;
    for (int o = 0; o < outs; o++) begin
      act = out_at(o);
      if (act.valid && out_ready_at(o)) begin
        if (exp_q[o].size() == 0)
          abort_run($sformatf("%s: %s delivered a flit that nobody sent", name, out_name(o)));
        exp = exp_q[o].pop_front();
        if (at_head[o])
          check_id({name, " ", out_name(o), " head"}, exp.data, act.data);
        check_flit({name, " ", out_name(o)}, exp, act);
        at_head[o] = act.last; // a tail makes the next flit a head.
      end
    end
  endtask

  task automatic advance_inputs();
    dii_pkg::dii_flit cur;
    logic             rdy;
    for (int p = 0; p <= nodes; p++) begin
      cur = (p < nodes) ? node_in[p] : ext_in;
      rdy = (p < nodes) ? node_in_ready[p] : ext_in_ready;
      if (cur.valid && rdy)
        void'(src_q[p].pop_front());
      cur = (src_q[p].size() > 0) ? src_q[p][0] : '0; // hold the front until taken.
      if (p < nodes)
        node_in[p] <= cur;
      else
        ext_in <= cur;
    end
  endtask

  task automatic drive_readies(input bit stall);
    logic [31:0] bits;
    bits = stall ? $random(seed) : '1;
    node_out_ready <= bits[nodes-1:0];
    ext_out_ready  <= bits[8];
    gw_local_ready <= bits[9];
  endtask

  task automatic run_traffic(input string name, input bit stall);
    int    cycles;
    string msg;
    cycles = 0;
    while (pending() > 0) begin
      @(posedge clk);
      watch_outputs(name);
      advance_inputs();
      drive_readies(stall);
      cycles++;
      if (cycles > max_cycles) begin
        msg = $sformatf("%s: timeout, an input port stopped accepting flits", name);
        for (int o = outs - 1; o >= 0; o--)
          if (exp_q[o].size() > 0)
            msg = $sformatf("%s: timeout, %s stalled with %0d flits still expected",
                            name, out_name(o), exp_q[o].size());
        abort_run(msg);
      end
    end
  endtask

  initial begin
    rst            = 1'b1;
    ext_in         = '0;
    ext_out_ready  = 1'b1;
    gw_local_ready = 1'b1;
    node_out_ready = '1;
    for (int p = 0; p < nodes; p++)
      node_in[p] = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_level("reset ext_out valid", 1'b0, ext_out.valid);
    check_level("reset gw_local valid", 1'b0, gw_local.valid);
    check_level("reset ext_in_ready", 1'b1, ext_in_ready);
    for (int o = 0; o < nodes; o++) begin
      check_level($sformatf("reset node_out[%0d] valid", o), 1'b0, node_out[o].valid);
      check_level($sformatf("reset node_in_ready[%0d]", o), 1'b1, node_in_ready[o]);
    end
    for (int round = 0; round < 2; round++) begin // second round stalls outputs at random.
      for (int g = 0; g < groups; g++) begin
        load_group(g);
        run_traffic($sformatf("%s group %0d", (round == 0) ? "open" : "stalled", g),
                    round == 1);
      end
    end
    repeat (2 * (nodes + 1)) begin // longer than a full trip around the ring.
      @(posedge clk);
      watch_outputs("drain");
      drive_readies(1'b0);
    end
    if (pending() == 0 && ring_idle()) begin
      $display("No errors");
      $finish;
    end else begin
      abort_run("the ring did not return to idle after the last worm");
    end
  end

endmodule

`default_nettype wire

// File: dii_ring_top.f
dii_pkg.sv
dii_flit_reg.sv
dii_worm_mux.sv
dii_ring_node.sv
dii_ring_ingress.sv
dii_gateway_demux.sv
dii_ring_top.sv
tb_dii_ring_top.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" \
  && verilator --binary --timing --top-module tb_dii_ring_top -f dii_ring_top.f -o sim_dii_ring \
  && ./obj_dir/sim_dii_ring | tee /dev/stderr | grep -q "^No errors$" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
